// ==== hdl/clint_consts.svh ====
`ifndef CLINT_CONSTS_SVH
`define CLINT_CONSTS_SVH

// number of harts, 1 to 64.
`define CLINT_CPU_NUM 4

// upper 16 address bits of the clint window.
`define CLINT_BASE 16'h0200

// register offsets inside the window.
`define CLINT_MSIP 16'h0000
`define CLINT_TIMECMP 16'h4000
`define CLINT_TIME 16'hBFF8

// clocks per mtime increment.
`define CLINT_TICK_DIV 4

`endif

// ==== hdl/clint_pkg.sv ====
`default_nettype none

package clint_pkg;

    // requester side of apb.
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic [31:0] paddr;
        logic        pwrite;
        logic [3:0]  pstrb;
        logic [31:0] pwdata;
    } apb_req_t;

    // completer side of apb.
    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
        logic        pready;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/apb_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module apb_decoder (
    input  wire                 clk,
    input  wire                 rstn,
    input  clint_pkg::apb_req_t req,
    output clint_pkg::apb_rsp_t rsp,
    output clint_pkg::apb_req_t clint_req,
    input  clint_pkg::apb_rsp_t clint_rsp
);

    logic hit;
    logic sel_hit;
    logic err_phase;

    assign hit       = req.paddr[31:16] == `CLINT_BASE; // window check.
    assign sel_hit   = req.psel && hit;
    assign err_phase = req.psel && req.penable && !hit; // unmapped access phase.

    always_comb begin
        clint_req      = req;
        clint_req.psel = sel_hit; // only select the clint inside its window.
    end

    always_comb begin
        if (sel_hit) begin
            rsp = clint_rsp;
        end else if (err_phase) begin
            rsp = '{prdata: 32'h0, pslverr: 1'b1, pready: 1'b1};
        end else begin
            rsp = '{prdata: 32'h0, pslverr: 1'b0, pready: 1'b1}; // idle or miss setup.
        end
    end

    // access phase must follow a setup phase.
    penable_after_psel: assert property (
        @(posedge clk) disable iff (!rstn)
        req.penable |-> $past(req.psel)
    ) else $error("penable high without psel in the previous cycle.");

endmodule

`default_nettype wire

// ==== hdl/mtime_prescaler.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module mtime_prescaler (
    input  wire  clk,
    input  wire  rstn,
    output logic tick
);

    localparam int CNT_W = (`CLINT_TICK_DIV > 1) ? $clog2(`CLINT_TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLINT_TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = cnt == CNT_LAST;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= wrap; // one cycle late, first pulse at TICK_DIV.
            cnt  <= wrap ? '0 : cnt + CNT_W'(1);
        end
    end

    tick_single_cycle: assert property (
        @(posedge clk) disable iff (!rstn)
        tick |=> !tick
    ) else $error("tick held for more than one cycle.");

endmodule

`default_nettype wire

// ==== hdl/clint.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       tick,
    input  clint_pkg::apb_req_t       req,
    output clint_pkg::apb_rsp_t       rsp,
    output logic [`CLINT_CPU_NUM-1:0] msip,
    output logic [`CLINT_CPU_NUM-1:0] mtip
);

    logic [15:0] offs;
    logic        wr_en;
    logic        setup;
    logic        time_lo_wr;
    logic        time_hi_wr;
    logic [63:0] mtimecmp [`CLINT_CPU_NUM];
    logic [63:0] mtime;
    logic [31:0] rdata_next;
    logic [31:0] prdata_q;

    // byte lane merge for pstrb.
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old,
        input logic [31:0] wdata,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign offs       = req.paddr[15:0];
    assign setup      = req.psel && !req.penable;
    assign wr_en      = req.psel && req.penable && req.pwrite; // end of access phase.
    assign time_lo_wr = wr_en && offs == `CLINT_TIME;
    assign time_hi_wr = wr_en && offs == `CLINT_TIME + 16'h4;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            msip <= '0;
        end else begin
            for (int i = 0; i < `CLINT_CPU_NUM; i++) begin
                if (wr_en && req.pstrb[0] && offs == `CLINT_MSIP + 16'(4 * i)) begin
                    msip[i] <= req.pwdata[0]; // only bit 0 is implemented.
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CLINT_CPU_NUM; i++) begin
                mtimecmp[i] <= 64'h0;
            end
        end else begin
            for (int i = 0; i < `CLINT_CPU_NUM; i++) begin
                if (wr_en && offs == `CLINT_TIMECMP + 16'(8 * i)) begin
                    mtimecmp[i][31:0] <= merge_bytes(mtimecmp[i][31:0], req.pwdata,
                                                     req.pstrb);
                end
                if (wr_en && offs == `CLINT_TIMECMP + 16'(8 * i + 4)) begin
                    mtimecmp[i][63:32] <= merge_bytes(mtimecmp[i][63:32], req.pwdata,
                                                      req.pstrb);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtime <= 64'h0;
        end else if (time_lo_wr) begin
            mtime[31:0] <= merge_bytes(mtime[31:0], req.pwdata, req.pstrb);
        end else if (time_hi_wr) begin
            mtime[63:32] <= merge_bytes(mtime[63:32], req.pwdata, req.pstrb);
        end else if (tick) begin
            mtime <= mtime + 64'd1; // writes win over the tick.
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtip <= '0;
        end else begin
            for (int i = 0; i < `CLINT_CPU_NUM; i++) begin
                mtip[i] <= mtime >= mtimecmp[i];
            end
        end
    end

    // or of all words matching the offset
    always_comb begin
        rdata_next = 32'h0;
        for (int i = 0; i < `CLINT_CPU_NUM; i++) begin
            if (offs == `CLINT_MSIP + 16'(4 * i)) begin
                rdata_next = rdata_next | {31'h0, msip[i]};
            end
            if (offs == `CLINT_TIMECMP + 16'(8 * i)) begin
                rdata_next = rdata_next | mtimecmp[i][31:0];
            end
            if (offs == `CLINT_TIMECMP + 16'(8 * i + 4)) begin
                rdata_next = rdata_next | mtimecmp[i][63:32];
            end
        end
        if (offs == `CLINT_TIME) begin
            rdata_next = rdata_next | mtime[31:0];
        end
        if (offs == `CLINT_TIME + 16'h4) begin
            rdata_next = rdata_next | mtime[63:32];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_q <= 32'h0;
        end else if (setup) begin
            prdata_q <= rdata_next; // valid through the access phase.
        end
    end

    assign rsp = '{prdata: prdata_q, pslverr: 1'b0, pready: 1'b1};

    mtime_no_decrease: assert property (
        @(posedge clk) disable iff (!rstn)
        !(time_lo_wr || time_hi_wr) |=> mtime >= $past(mtime)
    ) else $error("mtime decreased without a write.");

endmodule

`default_nettype wire

// ==== hdl/clint_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_subsys (
    input  wire                       clk,
    input  wire                       rstn,
    input  clint_pkg::apb_req_t       req,
    output clint_pkg::apb_rsp_t       rsp,
    output logic [`CLINT_CPU_NUM-1:0] msip,
    output logic [`CLINT_CPU_NUM-1:0] mtip
);

    clint_pkg::apb_req_t clint_req;
    clint_pkg::apb_rsp_t clint_rsp;
    logic                tick;

    apb_decoder u_apb_decoder (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .rsp       (rsp),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp)
    );

    mtime_prescaler u_mtime_prescaler (
        .clk  (clk),
        .rstn (rstn),
        .tick (tick)
    );

    clint u_clint (
        .clk  (clk),
        .rstn (rstn),
        .tick (tick),
        .req  (clint_req),
        .rsp  (clint_rsp),
        .msip (msip),
        .mtip (mtip)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clint_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module tb_clint_subsys;

    localparam int CPU         = `CLINT_CPU_NUM;
    localparam int DIV         = `CLINT_TICK_DIV;
    localparam int XFER_CYC    = 3; // setup, access, idle.
    localparam int N_XFER      = 56;
    localparam int ADV_CYC     = 400;
    localparam int IRQ_MARGIN  = 40;
    localparam int WAIT_CYC    = ADV_CYC + 50 * DIV + IRQ_MARGIN + 8;
    localparam int TIMEOUT_CYC = 16 + N_XFER * XFER_CYC + WAIT_CYC + 2000;

    logic                clk;
    logic                rstn;
    clint_pkg::apb_req_t req;
    clint_pkg::apb_rsp_t rsp;
    logic [CPU-1:0]      msip;
    logic [CPU-1:0]      mtip;

    int             err_total  = 0;
    int             bus_errs   = 0;
    int             pass_cnt   = 0;
    int             fail_cnt   = 0;
    int             test_start = 0;
    string          test_name  = "";
    logic [CPU-1:0] exp_msip;

    clint_subsys dut (
        .clk  (clk),
        .rstn (rstn),
        .req  (req),
        .rsp  (rsp),
        .msip (msip),
        .mtip (mtip)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    in_window_no_err: assert property (
        @(posedge clk) disable iff (!rstn)
        (req.psel && req.penable && req.paddr[31:16] == `CLINT_BASE) |-> !rsp.pslverr
    ) else begin
        $display("slave error on an access inside the clint window at %0t", $time);
        bus_errs++;
    end

    no_wait_state: assert property (
        @(posedge clk) disable iff (!rstn)
        (req.psel && req.penable) |-> rsp.pready
    ) else begin
        $display("pready low during an access phase at %0t", $time);
        bus_errs++;
    end

    function automatic logic [31:0] clint_addr(input logic [15:0] offs);
        return {`CLINT_BASE, offs};
    endfunction

    task automatic apb_xfer(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.paddr   = addr;
        req.pwrite  = write;
        req.pstrb   = 4'hf;
        req.pwdata  = wdata;
        @(negedge clk);
        req.penable = 1'b1;
        @(posedge clk);
        rdata = rsp.prdata; // req only moves on falling edges.
        err   = rsp.pslverr;
        @(negedge clk);
        req.psel    = 1'b0;
        req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused_rd;
        apb_xfer(1'b1, addr, wdata, unused_rd, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        value_match: assert (act === exp) else begin
            $display("ERROR %s (%s): expected %h, actual %h", test_name, name, exp, act);
            err_total++;
        end
    endtask

    task automatic check_range(input string name, input logic [31:0] lo,
                               input logic [31:0] hi, input logic [31:0] act);
        value_in_range: assert (act >= lo && act <= hi) else begin
            $display("ERROR %s (%s): expected %0d to %0d, actual %0d",
                     test_name, name, lo, hi, act);
            err_total++;
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = err_total + bus_errs;
    endtask

    task automatic finish_test();
        int errs;
        errs = err_total + bus_errs - test_start;
        if (errs == 0) begin
            $display("%s: passed", test_name);
            pass_cnt++;
        end else begin
            $display("%s: failed with %0d errors", test_name, errs);
            fail_cnt++;
        end
    endtask

    initial begin
        #(TIMEOUT_CYC * 40);
        $display("watchdog expired after %0d cycles, the run hung", TIMEOUT_CYC);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] wd;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] lo_w;
        logic [31:0] hi_w;
        logic [63:0] cmp_model [CPU];
        logic [63:0] target;
        logic        err;
        int          h;
        int          delta;
        int          cnt;
        void'($urandom(56));
        req      = '0;
        rstn     = 1'b0;
        exp_msip = '0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        start_test("msip");
        for (int i = 0; i < CPU; i++) begin
            wd          = $urandom;
            exp_msip[i] = wd[0]; // only bit 0 is stored.
            apb_write(clint_addr(`CLINT_MSIP + 16'(4 * i)), wd, err);
            apb_read(clint_addr(`CLINT_MSIP + 16'(4 * i)), rd, err);
            compare_value("msip read", {31'h0, wd[0]}, rd);
            compare_value("msip port", 32'(exp_msip), 32'(msip));
        end
        finish_test();

        start_test("mtimecmp");
        for (int i = 0; i < CPU; i++) begin
            cmp_model[i] = {$urandom, $urandom};
            apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * i)), cmp_model[i][31:0], err);
            apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * i + 4)), cmp_model[i][63:32], err);
        end
        for (int i = 0; i < CPU; i++) begin
            apb_read(clint_addr(`CLINT_TIMECMP + 16'(8 * i)), rd, err);
            compare_value("mtimecmp low", cmp_model[i][31:0], rd);
            apb_read(clint_addr(`CLINT_TIMECMP + 16'(8 * i + 4)), rd, err);
            compare_value("mtimecmp high", cmp_model[i][63:32], rd);
        end
        for (int i = 0; i < CPU; i++) begin
            cmp_model[i] = '1;
            apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * i)), 32'hffff_ffff, err);
            apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * i + 4)), 32'hffff_ffff, err);
        end
        repeat (2) @(negedge clk);
        compare_value("mtip at max mtimecmp", 32'h0, 32'(mtip));
        finish_test();

        start_test("mtime advance");
        apb_read(clint_addr(`CLINT_TIME), t0, err);
        repeat (ADV_CYC) @(negedge clk);
        apb_read(clint_addr(`CLINT_TIME), t1, err);
        check_range("mtime advance", ADV_CYC / DIV - 2, ADV_CYC / DIV + 2, t1 - t0);
        finish_test();

        start_test("mtime load");
        hi_w = $urandom;
        lo_w = $urandom & 32'h7fff_ffff; // keeps a carry out of the low word away.
        apb_write(clint_addr(`CLINT_TIME + 16'h4), hi_w, err);
        apb_write(clint_addr(`CLINT_TIME), lo_w, err);
        apb_read(clint_addr(`CLINT_TIME + 16'h4), rd, err);
        compare_value("mtime high", hi_w, rd);
        apb_read(clint_addr(`CLINT_TIME), rd, err);
        check_range("mtime low", lo_w, lo_w + 32'(2 * XFER_CYC / DIV + 2), rd);
        finish_test();

        start_test("timer interrupt");
        h     = $urandom % CPU;
        delta = 20 + $urandom % 31;
        apb_read(clint_addr(`CLINT_TIME), t0, err);
        apb_read(clint_addr(`CLINT_TIME + 16'h4), t1, err);
        target = {t1, t0} + 64'(delta);
        // high half stays all ones until the low half is set.
        apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * h)), target[31:0], err);
        apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * h + 4)), target[63:32], err);
        cnt = 0;
        while (!mtip[h] && cnt <= delta * DIV + IRQ_MARGIN) begin
            @(negedge clk);
            cnt++;
        end
        irq_rises: assert (mtip[h]) else begin
            $display("mtip of hart %0d did not rise within %0d cycles", h, cnt);
            err_total++;
        end
        check_range("mtip delay", delta * DIV / 2, delta * DIV + IRQ_MARGIN, cnt);
        apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * h)), 32'hffff_ffff, err);
        apb_write(clint_addr(`CLINT_TIMECMP + 16'(8 * h + 4)), 32'hffff_ffff, err);
        repeat (2) @(negedge clk);
        compare_value("mtip cleared", 32'h0, 32'(mtip[h]));
        finish_test();

        start_test("address decode");
        apb_read(32'h1000_0000 | ($urandom & 32'h0000_fffc), rd, err);
        compare_value("unmapped read error", 32'h1, 32'(err));
        compare_value("unmapped read data", 32'h0, rd);
        // low address bits alias msip of hart 0 and mtimecmp of hart 0.
        apb_write(32'h0300_0000 | 32'(`CLINT_MSIP), {31'h0, ~exp_msip[0]}, err);
        compare_value("unmapped write error", 32'h1, 32'(err));
        apb_write(32'h0300_0000 | 32'(`CLINT_TIMECMP), $urandom, err);
        compare_value("unmapped write error", 32'h1, 32'(err));
        for (int i = 0; i < CPU; i++) begin
            apb_read(clint_addr(`CLINT_MSIP + 16'(4 * i)), rd, err);
            compare_value("msip unchanged", {31'h0, exp_msip[i]}, rd);
            compare_value("mapped read error", 32'h0, 32'(err));
        end
        apb_read(clint_addr(`CLINT_TIMECMP), rd, err);
        compare_value("mtimecmp unchanged", cmp_model[0][31:0], rd);
        compare_value("msip port unchanged", 32'(exp_msip), 32'(msip));
        finish_test();

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_total + bus_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/clint_pkg.sv
hdl/apb_decoder.sv
hdl/mtime_prescaler.sv
hdl/clint.sv
hdl/clint_subsys.sv
tb/tb_clint_subsys.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_clint_subsys
FLIST     = vlog.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass or fail comes from the pass message in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
